//--- verilog/aluPkg.sv
/*
 * shared widths, credit and queue sizes, opcode enum
 * and the packed operation, result and flag structs of the execution unit
 */
`default_nettype none

package aluPkg;

	// data path widths
	localparam int WORD_W = 32;
	localparam int TAG_W = 4;
	localparam int SHAMT_W = 5;

	// input queue entries, also the producer credits after reset
	localparam int QUEUE_DEPTH = 4;
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);

	// output credits owned by the unit after reset
	localparam int RES_CREDITS = 2;
	localparam int CREDIT_W = 3;

	typedef logic [WORD_W-1:0] wordT;
	typedef logic [TAG_W-1:0] tagT;
	typedef logic [SHAMT_W-1:0] shamtT;
	typedef logic [CREDIT_W-1:0] creditT;

	// register port address
	typedef logic [1:0] cfgAddrT;
	localparam cfgAddrT CTRL = 2'd0;
	localparam cfgAddrT STATUS = 2'd1;
	localparam cfgAddrT COUNT = 2'd2;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLL,
		SRL,
		SRA,
		SLT
	} aluOpcodeT;

	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
		logic overflow;
	} aluFlagsT;

	// 72 bits: opcode, operands, tag
	typedef struct packed {
		aluOpcodeT opcode;
		wordT a;
		wordT b;
		tagT tag;
	} aluOpT;

	// 40 bits: result, flags, tag
	typedef struct packed {
		wordT result;
		aluFlagsT flags;
		tagT tag;
	} aluResT;

endpackage

`default_nettype wire

//--- verilog/claAdder32.sv
/*
 * carry-lookahead adders: 4-bit block, 16-bit block from four 4-bit blocks,
 * and the 32-bit adder from two 16-bit blocks with carry out and overflow
 */
`timescale 1ns/100ps
`default_nettype none

module cla4 (
	input wire logic [3:0] inA,
	input wire logic [3:0] inB,
	input wire logic cin,
	output logic [3:0] sum,
	output logic pGroup,
	output logic gGroup,
	output logic c3
);
	// per-bit propagate and generate
	logic [3:0] p;
	logic [3:0] g;
	// carry into each bit
	logic [3:0] c;

	assign p = inA ^ inB;
	assign g = inA & inB;

	// lookahead carries, two-level sum of products
	assign c[0] = cin;
	assign c[1] = g[0] | (p[0] & cin);
	assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
	assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);

	// group signals for the next lookahead level
	assign pGroup = &p;
	assign gGroup = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);

	assign sum = p ^ c;
	assign c3 = c[3];
endmodule

module cla16 (
	input wire logic [15:0] inA,
	input wire logic [15:0] inB,
	input wire logic cin,
	output logic [15:0] sum,
	output logic pGroup,
	output logic gGroup,
	output logic cMsb
);
	// group propagate and generate of the four blocks
	logic [3:0] p;
	logic [3:0] g;
	// carry into each block
	logic [3:0] c;

	// second-level lookahead, no ripple between blocks
	assign c[0] = cin;
	assign c[1] = g[0] | (p[0] & cin);
	assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
	assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);

	assign pGroup = &p;
	assign gGroup = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);

	// only the top block's bit-3 carry is the carry into bit 15
	cla4 u_cla4_0 (.inA(inA[3:0]), .inB(inB[3:0]), .cin(c[0]), .sum(sum[3:0]),
		.pGroup(p[0]), .gGroup(g[0]), .c3());
	cla4 u_cla4_1 (.inA(inA[7:4]), .inB(inB[7:4]), .cin(c[1]), .sum(sum[7:4]),
		.pGroup(p[1]), .gGroup(g[1]), .c3());
	cla4 u_cla4_2 (.inA(inA[11:8]), .inB(inB[11:8]), .cin(c[2]), .sum(sum[11:8]),
		.pGroup(p[2]), .gGroup(g[2]), .c3());
	cla4 u_cla4_3 (.inA(inA[15:12]), .inB(inB[15:12]), .cin(c[3]), .sum(sum[15:12]),
		.pGroup(p[3]), .gGroup(g[3]), .c3(cMsb));
endmodule

module claAdder32 (
	input wire aluPkg::wordT inA,
	input wire aluPkg::wordT inB,
	input wire logic cin,
	output aluPkg::wordT sum,
	output logic cout,
	output logic overflow
);
	logic [1:0] p;
	logic [1:0] g;
	// carry into the upper half
	logic cHi;
	// carry into bit 31
	logic c31;

	// top-level lookahead over the two halves
	assign cHi = g[0] | (p[0] & cin);
	assign cout = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);

	cla16 u_cla16_0 (.inA(inA[15:0]), .inB(inB[15:0]), .cin(cin), .sum(sum[15:0]),
		.pGroup(p[0]), .gGroup(g[0]), .cMsb());
	cla16 u_cla16_1 (.inA(inA[31:16]), .inB(inB[31:16]), .cin(cHi), .sum(sum[31:16]),
		.pGroup(p[1]), .gGroup(g[1]), .cMsb(c31));

	// signed overflow when carry into and out of the sign bit differ
	assign overflow = cout ^ c31;
endmodule

`default_nettype wire

//--- verilog/aluLogicShift.sv
/*
 * bitwise logic and barrel shift unit
 * AND, OR, XOR, SLL, SRL, SRA on one operand pair
 */
`timescale 1ns/100ps
`default_nettype none

module aluLogicShift (
	input wire aluPkg::aluOpcodeT opcode,
	input wire aluPkg::wordT a,
	input wire aluPkg::wordT b,
	output aluPkg::wordT result
);
	// shift amount from the low bits of b only
	aluPkg::shamtT shamt;

	assign shamt = b[aluPkg::SHAMT_W-1:0];

	always_comb begin
		case (opcode)
			aluPkg::AND: begin
				result = a & b;
			end
			aluPkg::OR: begin
				result = a | b;
			end
			aluPkg::XOR: begin
				result = a ^ b;
			end
			aluPkg::SLL: begin
				result = a << shamt;
			end
			aluPkg::SRL: begin
				result = a >> shamt;
			end
			aluPkg::SRA: begin
				// sign bit fills from the left
				result = aluPkg::wordT'($signed(a) >>> shamt);
			end
			default: begin
				// add, sub and slt come from the adder
				result = '0;
			end
		endcase
	end
endmodule

`default_nettype wire

//--- verilog/aluRegs.sv
/*
 * configuration and status registers behind a synchronous register port
 * saturation enable, sticky overflow and result counter
 */
`timescale 1ns/100ps
`default_nettype none

module aluRegs (
	input wire logic clk,
	input wire logic arstN,
	input wire logic cfgWrite,
	input wire aluPkg::cfgAddrT cfgAddr,
	input wire aluPkg::wordT cfgWdata,
	input wire logic resFire,
	input wire logic resOvf,
	output aluPkg::wordT cfgRdata,
	output logic satEn
);
	logic stickyOvf;
	aluPkg::wordT resCount;

	logic wrCtrl;
	logic wrStatus;
	logic wrCount;

	assign wrCtrl = cfgWrite && (cfgAddr == aluPkg::CTRL);
	assign wrStatus = cfgWrite && (cfgAddr == aluPkg::STATUS);
	assign wrCount = cfgWrite && (cfgAddr == aluPkg::COUNT);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			satEn <= 1'b0;
			stickyOvf <= 1'b0;
			resCount <= '0;
		end else begin
			if (wrCtrl) begin
				satEn <= cfgWdata[0];
			end
			// a new overflow wins over a clear in the same cycle
			if (resFire && resOvf) begin
				stickyOvf <= 1'b1;
			end else if (wrStatus && cfgWdata[0]) begin
				stickyOvf <= 1'b0;
			end
			// write restarts the count, a result on that edge still counts
			if (wrCount) begin
				resCount <= aluPkg::wordT'(resFire);
			end else begin
				resCount <= resCount + aluPkg::wordT'(resFire);
			end
		end
	end

	// read data straight from the address
	always_comb begin
		case (cfgAddr)
			aluPkg::CTRL: cfgRdata = {{(aluPkg::WORD_W-1){1'b0}}, satEn};
			aluPkg::STATUS: cfgRdata = {{(aluPkg::WORD_W-1){1'b0}}, stickyOvf};
			aluPkg::COUNT: cfgRdata = resCount;
			default: cfgRdata = '0;
		endcase
	end
endmodule

`default_nettype wire

//--- verilog/opQueue.sv
/*
 * credited input queue of operations
 * circular buffer, one credit pulse returned per pop
 */
`timescale 1ns/100ps
`default_nettype none

module opQueue (
	input wire logic clk,
	input wire logic arstN,
	input wire logic opValid,
	input wire aluPkg::aluOpT op,
	input wire logic pop,
	output logic headValid,
	output aluPkg::aluOpT head,
	output logic opCredit
);
	aluPkg::aluOpT mem [aluPkg::QUEUE_DEPTH];

	logic [aluPkg::QPTR_W-1:0] wrPtr;
	logic [aluPkg::QPTR_W-1:0] rdPtr;
	// occupancy, 0 to QUEUE_DEPTH
	logic [aluPkg::QPTR_W:0] used;

	logic full;
	logic doWrite;
	logic doPop;

	assign full = (used == (aluPkg::QPTR_W + 1)'(aluPkg::QUEUE_DEPTH));
	assign headValid = (used != '0);
	assign head = mem[rdPtr];

	// write into a full queue is a producer error and is dropped
	assign doWrite = opValid && !full;
	assign doPop = pop && headValid;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			used <= '0;
			opCredit <= 1'b0;
		end else begin
			if (doWrite) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doWrite, doPop})
				2'b10: used <= used + 1'b1;
				2'b01: used <= used - 1'b1;
				default: used <= used;
			endcase
			// one credit back per entry freed
			opCredit <= doPop;
		end
	end

	// entry storage
	always_ff @(posedge clk) begin
		if (doWrite) begin
			mem[wrPtr] <= op;
		end
	end
endmodule

`default_nettype wire

//--- verilog/aluCore.sv
/*
 * operand preparation, result select, flags and saturation
 * result register and output credit counter
 */
`timescale 1ns/100ps
`default_nettype none

module aluCore (
	input wire logic clk,
	input wire logic arstN,
	input wire logic headValid,
	input wire aluPkg::aluOpT head,
	input wire logic satEn,
	input wire aluPkg::wordT sum,
	input wire logic cout,
	input wire logic overflow,
	input wire aluPkg::wordT logicResult,
	input wire logic resCredit,
	output logic pop,
	output aluPkg::wordT addB,
	output logic addCin,
	output logic resValid,
	output aluPkg::aluResT res,
	output logic resFire,
	output logic resOvf
);
	// a credit is spent when its result leaves
	aluPkg::creditT outCredits;

	logic isArith;
	logic isSub;
	aluPkg::wordT selResult;
	aluPkg::aluResT nextRes;

	assign isArith = (head.opcode == aluPkg::ADD) || (head.opcode == aluPkg::SUB);
	// slt compares by subtracting
	assign isSub = (head.opcode == aluPkg::SUB) || (head.opcode == aluPkg::SLT);

	// two's complement subtract through the adder
	assign addB = isSub ? ~head.b : head.b;
	assign addCin = isSub;

	// pop only with a credit not already held by the result in flight
	assign pop = headValid && (outCredits != '0) &&
		!(resValid && (outCredits == aluPkg::creditT'(1)));

	always_comb begin
		if (isArith && satEn && overflow) begin
			// clamp toward the sign of a
			selResult = head.a[aluPkg::WORD_W-1] ? 32'h8000_0000 : 32'h7FFF_FFFF;
		end else if (isArith) begin
			selResult = sum;
		end else if (head.opcode == aluPkg::SLT) begin
			// signed less than is negative xor overflow of a - b
			selResult = {{(aluPkg::WORD_W-1){1'b0}}, sum[aluPkg::WORD_W-1] ^ overflow};
		end else begin
			selResult = logicResult;
		end
		nextRes.result = selResult;
		nextRes.flags.zero = (selResult == '0);
		nextRes.flags.negative = selResult[aluPkg::WORD_W-1];
		// carry and overflow only mean something for add and sub
		nextRes.flags.carry = isArith && cout;
		nextRes.flags.overflow = isArith && overflow;
		nextRes.tag = head.tag;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resValid <= 1'b0;
			outCredits <= aluPkg::creditT'(aluPkg::RES_CREDITS);
		end else begin
			resValid <= pop;
			outCredits <= outCredits + aluPkg::creditT'(resCredit) - aluPkg::creditT'(resValid);
		end
	end

	// result payload captured at the pop edge
	always_ff @(posedge clk) begin
		if (pop) begin
			res <= nextRes;
		end
	end

	// status events for the register block
	assign resFire = resValid;
	assign resOvf = resValid && res.flags.overflow;
endmodule

`default_nettype wire

//--- verilog/aluUnit.sv
/*
 * top of the execution unit
 * input queue, core, adder, logic unit and register block
 */
`timescale 1ns/100ps
`default_nettype none

module aluUnit (
	input wire logic clk,
	input wire logic arstN,
	input wire logic opValid,
	input wire aluPkg::aluOpT op,
	input wire logic resCredit,
	input wire logic cfgWrite,
	input wire aluPkg::cfgAddrT cfgAddr,
	input wire aluPkg::wordT cfgWdata,
	output logic opCredit,
	output logic resValid,
	output aluPkg::aluResT res,
	output aluPkg::wordT cfgRdata
);
	// queue head
	logic headValid;
	aluPkg::aluOpT head;
	logic pop;

	// adder paths
	aluPkg::wordT addB;
	logic addCin;
	aluPkg::wordT sum;
	logic cout;
	logic overflow;

	aluPkg::wordT logicResult;

	// core to registers
	logic satEn;
	logic resFire;
	logic resOvf;

	opQueue u_opQueue (.clk(clk), .arstN(arstN), .opValid(opValid), .op(op), .pop(pop),
		.headValid(headValid), .head(head), .opCredit(opCredit));

	// adder and logic unit work straight off the queue head
	claAdder32 u_claAdder32 (.inA(head.a), .inB(addB), .cin(addCin), .sum(sum),
		.cout(cout), .overflow(overflow));

	aluLogicShift u_aluLogicShift (.opcode(head.opcode), .a(head.a), .b(head.b),
		.result(logicResult));

	aluCore u_aluCore (.clk(clk), .arstN(arstN), .headValid(headValid), .head(head),
		.satEn(satEn), .sum(sum), .cout(cout), .overflow(overflow),
		.logicResult(logicResult), .resCredit(resCredit), .pop(pop), .addB(addB),
		.addCin(addCin), .resValid(resValid), .res(res), .resFire(resFire),
		.resOvf(resOvf));

	aluRegs u_aluRegs (.clk(clk), .arstN(arstN), .cfgWrite(cfgWrite), .cfgAddr(cfgAddr),
		.cfgWdata(cfgWdata), .resFire(resFire), .resOvf(resOvf), .cfgRdata(cfgRdata),
		.satEn(satEn));
endmodule

`default_nettype wire

//--- testbench/aluUnit_props.sv
/*
 * concurrent assertions on output credits, queue writes and credit pulses
 * bound into the core and the input queue
 */
`timescale 1ns/100ps
`default_nettype none

module aluUnitProps (
	input wire logic clk,
	input wire logic arstN,
	input wire logic resValid,
	input wire aluPkg::creditT outCredits,
	input wire logic opValid,
	input wire logic full,
	input wire logic doPop,
	input wire logic opCredit
);
	// a result only leaves while a credit is held
	assert property (@(posedge clk) disable iff (!arstN) resValid |-> (outCredits != '0))
		else $error("result sent with no output credit");

	// producer must never write into a full queue
	assert property (@(posedge clk) disable iff (!arstN) opValid |-> !full)
		else $error("operation written into a full queue");

	// no credit pulses during reset
	assert property (@(posedge clk) !arstN |-> !opCredit)
		else $error("credit pulse while in reset");

	// each credit pulse follows a pop one cycle earlier
	assert property (@(posedge clk) disable iff (!arstN) opCredit |-> $past(doPop))
		else $error("credit pulse without a preceding pop");
endmodule

// core side with the queue signals tied off
bind aluCore aluUnitProps u_coreProps (.clk(clk), .arstN(arstN), .resValid(resValid),
	.outCredits(outCredits), .opValid(1'b0), .full(1'b0), .doPop(1'b0), .opCredit(1'b0));

// queue side with the core signals tied to a harmless value
bind opQueue aluUnitProps u_queueProps (.clk(clk), .arstN(arstN), .resValid(1'b0),
	.outCredits(3'd1), .opValid(opValid), .full(full), .doPop(doPop), .opCredit(opCredit));

`default_nettype wire

//--- testbench/aluUnitTb.sv
/*
 * testbench for the execution unit: clock, reset, reference model,
 * result monitor, consumer credit return, directed tests and watchdog
 */
`timescale 1ns/100ps
`default_nettype none

module aluUnitTb;
	// operations issued over all tests, sizes the watchdog
	localparam int NUM_OPS = 8 + 30 + 5 + 5 + 6 + 200;
	localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 500;

	logic clk = 1'b0;
	logic arstN;
	logic opValid;
	aluPkg::aluOpT op;
	logic resCredit;
	logic cfgWrite;
	aluPkg::cfgAddrT cfgAddr;
	aluPkg::wordT cfgWdata;
	logic opCredit;
	logic resValid;
	aluPkg::aluResT res;
	aluPkg::wordT cfgRdata;

	// producer and consumer bookkeeping
	int opsSent = 0;
	int creditPulses = 0;
	// results seen and credits handed back by the consumer
	int resultsSeen = 0;
	int creditsGiven = 0;
	// 0 return at once, 1 withhold, 2 random
	int creditMode = 0;
	int cycle = 0;
	int acceptCycle = 0;
	aluPkg::tagT nextTag = '0;
	logic modelSatEn = 1'b0;
	logic [31:0] rngState = 32'd63;
	logic [31:0] creditRng = 32'd63;
	aluPkg::aluResT expQ[$];
	aluPkg::aluResT gotQ[$];
	int gotCycleQ[$];

	int errors = 0;
	int testErrStart = 0;
	int testsPassed = 0;
	int testsFailed = 0;

	aluUnit u_aluUnit (.clk(clk), .arstN(arstN), .opValid(opValid), .op(op),
		.resCredit(resCredit), .cfgWrite(cfgWrite), .cfgAddr(cfgAddr), .cfgWdata(cfgWdata),
		.opCredit(opCredit), .resValid(resValid), .res(res), .cfgRdata(cfgRdata));

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// behavioral model of one operation
	function automatic aluPkg::aluResT refModel(input aluPkg::aluOpT o, input logic sat);
		aluPkg::aluResT r;
		logic [32:0] wide;
		logic [31:0] val;
		logic [4:0] sh;
		logic carry;
		logic ovf;
		logic arith;
		sh = o.b[4:0];
		carry = 1'b0;
		ovf = 1'b0;
		arith = 1'b0;
		case (o.opcode)
			aluPkg::ADD: begin
				wide = {1'b0, o.a} + {1'b0, o.b};
				val = wide[31:0];
				carry = wide[32];
				// same-sign operands with a result of the other sign
				ovf = (o.a[31] == o.b[31]) && (val[31] != o.a[31]);
				arith = 1'b1;
			end
			aluPkg::SUB: begin
				val = o.a - o.b;
				// carry means no borrow
				carry = (o.a >= o.b);
				ovf = (o.a[31] != o.b[31]) && (val[31] != o.a[31]);
				arith = 1'b1;
			end
			aluPkg::AND: val = o.a & o.b;
			aluPkg::OR: val = o.a | o.b;
			aluPkg::XOR: val = o.a ^ o.b;
			aluPkg::SLL: val = o.a << sh;
			aluPkg::SRL: val = o.a >> sh;
			// logical shift, then fill the vacated top bits with the sign
			aluPkg::SRA: val = (o.a >> sh) | (o.a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
			aluPkg::SLT: val = ($signed(o.a) < $signed(o.b)) ? 32'd1 : 32'd0;
			default: val = 32'h0;
		endcase
		// the wrapped sign is the opposite of the true sign
		if (arith && sat && ovf) begin
			val = val[31] ? 32'h7FFF_FFFF : 32'h8000_0000;
		end
		r.result = val;
		r.flags.zero = (val == 32'h0);
		r.flags.negative = val[31];
		r.flags.carry = arith && carry;
		r.flags.overflow = ovf;
		r.tag = o.tag;
		return r;
	endfunction

	function automatic int creditsAvail();
		return aluPkg::QUEUE_DEPTH - opsSent + creditPulses;
	endfunction

	// outputs sampled at the rising edge before the DUT flops update
	always @(posedge clk) begin
		cycle++;
		if (opCredit) begin
			creditPulses++;
		end
		if (resValid) begin
			gotQ.push_back(res);
			gotCycleQ.push_back(cycle);
			resultsSeen++;
		end
	end

	// consumer hands credits back per the current mode
	initial begin
		resCredit = 1'b0;
		forever begin
			@(negedge clk);
			creditRng = xorshift(creditRng);
			if (resultsSeen > creditsGiven &&
				(creditMode == 0 || (creditMode == 2 && creditRng[7]))) begin
				resCredit = 1'b1;
				creditsGiven++;
			end else begin
				resCredit = 1'b0;
			end
		end
	end

	task automatic reportError(input string msg);
		errors++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	// all tasks start and end on a falling edge
	task automatic sendOp(input aluPkg::aluOpcodeT opc, input aluPkg::wordT a,
		input aluPkg::wordT b);
		aluPkg::aluOpT o;
		while (creditsAvail() == 0) begin
			@(negedge clk);
		end
		o.opcode = opc;
		o.a = a;
		o.b = b;
		o.tag = nextTag;
		nextTag = nextTag + 4'd1;
		op = o;
		opValid = 1'b1;
		opsSent++;
		acceptCycle = cycle + 1;
		expQ.push_back(refModel(o, modelSatEn));
		@(negedge clk);
		opValid = 1'b0;
	endtask

	task automatic waitResults(input int n);
		while (gotQ.size() < n) begin
			@(negedge clk);
		end
	endtask

	task automatic compareResults();
		aluPkg::aluResT expRes;
		aluPkg::aluResT gotRes;
		while (expQ.size() > 0 && gotQ.size() > 0) begin
			expRes = expQ.pop_front();
			gotRes = gotQ.pop_front();
			void'(gotCycleQ.pop_front());
			if (gotRes !== expRes) begin
				reportError($sformatf("tag %0d got %h flags %b, expected tag %0d %h flags %b",
					gotRes.tag, gotRes.result, gotRes.flags, expRes.tag, expRes.result,
					expRes.flags));
			end
		end
		if (expQ.size() != 0 || gotQ.size() != 0) begin
			errors++;
			$display("result count wrong: %0d results missing, %0d unexpected results",
				expQ.size(), gotQ.size());
		end
		expQ.delete();
		gotQ.delete();
		gotCycleQ.delete();
	endtask

	// one operation on an idle unit with a latency check
	task automatic runSingle(input aluPkg::aluOpcodeT opc, input aluPkg::wordT a,
		input aluPkg::wordT b);
		sendOp(opc, a, b);
		waitResults(1);
		if (gotCycleQ[0] - acceptCycle != 2) begin
			reportError($sformatf("tag %0d seen %0d cycles after acceptance, expected 2",
				gotQ[0].tag, gotCycleQ[0] - acceptCycle));
		end
		compareResults();
	endtask

	task automatic writeReg(input aluPkg::cfgAddrT addr, input aluPkg::wordT data);
		cfgAddr = addr;
		cfgWdata = data;
		cfgWrite = 1'b1;
		@(negedge clk);
		cfgWrite = 1'b0;
	endtask

	task automatic checkReg(input aluPkg::cfgAddrT addr, input aluPkg::wordT expected);
		aluPkg::wordT value;
		cfgAddr = addr;
		@(negedge clk);
		value = cfgRdata;
		if (value !== expected) begin
			reportError($sformatf("register %0d read %h, expected %h", addr, value, expected));
		end
	endtask

	// wait until every credit on both sides is back home
	task automatic settle();
		creditMode = 0;
		while (resultsSeen != creditsGiven || creditsAvail() != aluPkg::QUEUE_DEPTH) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
	endtask

	task automatic endTest(input string name);
		if (errors == testErrStart) begin
			testsPassed++;
			$display("test %s: pass", name);
		end else begin
			testsFailed++;
			$display("test %s: fail, %0d errors", name, errors - testErrStart);
		end
	endtask

	task automatic testAddSub();
		testErrStart = errors;
		runSingle(aluPkg::ADD, 32'h7FFF_FFFF, 32'h0000_0001);
		runSingle(aluPkg::SUB, 32'h8000_0000, 32'h0000_0001);
		runSingle(aluPkg::ADD, 32'hFFFF_FFFF, 32'h0000_0001);
		runSingle(aluPkg::SUB, 32'h1234_5678, 32'h1234_5678);
		runSingle(aluPkg::ADD, 32'h0000_0000, 32'h0000_0000);
		runSingle(aluPkg::SUB, 32'h0000_0000, 32'h0000_0001);
		runSingle(aluPkg::ADD, 32'h8000_0000, 32'h8000_0000);
		runSingle(aluPkg::SUB, 32'h7FFF_FFFF, 32'hFFFF_FFFF);
		settle();
		endTest("add and sub edge operands");
	endtask

	task automatic testLogicShift();
		aluPkg::wordT amounts [4];
		int total;
		testErrStart = errors;
		// 37 keeps only its low five bits
		amounts[0] = 32'd0;
		amounts[1] = 32'd1;
		amounts[2] = 32'd31;
		amounts[3] = 32'd37;
		for (int k = 0; k < 6; k++) begin
			for (int s = 0; s < 4; s++) begin
				sendOp(aluPkg::aluOpcodeT'(4'(k + 2)), 32'h9ABC_DEF1, amounts[s]);
			end
		end
		sendOp(aluPkg::SLT, 32'hFFFF_FFFF, 32'h0000_0001);
		sendOp(aluPkg::SLT, 32'h0000_0001, 32'hFFFF_FFFF);
		sendOp(aluPkg::SLT, 32'h0000_0005, 32'h0000_0005);
		sendOp(aluPkg::SLT, 32'h8000_0000, 32'h7FFF_FFFF);
		sendOp(aluPkg::SLT, 32'h7FFF_FFFF, 32'h8000_0000);
		sendOp(aluPkg::SLT, 32'hFFFF_FFFD, 32'hFFFF_FFFE);
		total = expQ.size();
		waitResults(total);
		compareResults();
		settle();
		endTest("logic, shift and slt");
	endtask

	task automatic testSaturate();
		testErrStart = errors;
		writeReg(aluPkg::CTRL, 32'd1);
		modelSatEn = 1'b1;
		checkReg(aluPkg::CTRL, 32'd1);
		runSingle(aluPkg::ADD, 32'h7FFF_FFFF, 32'h0000_0001);
		runSingle(aluPkg::SUB, 32'h8000_0000, 32'h0000_0001);
		runSingle(aluPkg::ADD, 32'h8000_0000, 32'h8000_0000);
		runSingle(aluPkg::SUB, 32'h7FFF_FFFF, 32'hFFFF_FFFF);
		writeReg(aluPkg::CTRL, 32'd0);
		modelSatEn = 1'b0;
		// wraps again
		runSingle(aluPkg::ADD, 32'h7FFF_FFFF, 32'h0000_0001);
		settle();
		endTest("signed saturation");
	endtask

	task automatic testStatus();
		testErrStart = errors;
		writeReg(aluPkg::STATUS, 32'd1);
		writeReg(aluPkg::COUNT, 32'd0);
		runSingle(aluPkg::ADD, 32'h7FFF_FFFF, 32'h0000_0001);
		checkReg(aluPkg::STATUS, 32'd1);
		// sticky across a clean result
		runSingle(aluPkg::ADD, 32'h0000_0001, 32'h0000_0002);
		checkReg(aluPkg::STATUS, 32'd1);
		writeReg(aluPkg::STATUS, 32'd1);
		checkReg(aluPkg::STATUS, 32'd0);
		checkReg(aluPkg::COUNT, 32'd2);
		runSingle(aluPkg::XOR, 32'h0F0F_0F0F, 32'hFFFF_0000);
		runSingle(aluPkg::SUB, 32'h0000_0003, 32'h0000_0007);
		runSingle(aluPkg::SLL, 32'h0000_0001, 32'h0000_0004);
		checkReg(aluPkg::COUNT, 32'd5);
		settle();
		endTest("sticky overflow and result count");
	endtask

	task automatic testBackPressure();
		int total;
		testErrStart = errors;
		total = aluPkg::RES_CREDITS + aluPkg::QUEUE_DEPTH;
		creditMode = 1;
		for (int i = 0; i < total; i++) begin
			sendOp(aluPkg::ADD, 32'(i), 32'd100);
		end
		// give the unit time to push out anything it could
		repeat (20) @(negedge clk);
		if (gotQ.size() != aluPkg::RES_CREDITS) begin
			reportError($sformatf("%0d results with credits withheld, expected %0d",
				gotQ.size(), aluPkg::RES_CREDITS));
		end
		if (creditsAvail() != 0) begin
			reportError($sformatf("producer holds %0d credits, expected 0", creditsAvail()));
		end
		creditMode = 0;
		waitResults(total);
		// the last credit pulse is sampled together with the last result
		if (creditPulses != opsSent) begin
			reportError($sformatf("%0d credit pulses for %0d operations", creditPulses, opsSent));
		end
		compareResults();
		settle();
		endTest("back-pressure");
	endtask

	task automatic testRandom();
		logic [31:0] r;
		aluPkg::wordT a;
		aluPkg::wordT b;
		testErrStart = errors;
		writeReg(aluPkg::CTRL, 32'd1);
		modelSatEn = 1'b1;
		creditMode = 2;
		for (int i = 0; i < 200; i++) begin
			rngState = xorshift(rngState);
			r = rngState;
			rngState = xorshift(rngState);
			a = rngState;
			rngState = xorshift(rngState);
			b = rngState;
			sendOp(aluPkg::aluOpcodeT'(4'(r % 32'd9)), a, b);
			// occasional idle gap
			if (r[9]) begin
				@(negedge clk);
			end
		end
		waitResults(200);
		compareResults();
		settle();
		writeReg(aluPkg::CTRL, 32'd0);
		modelSatEn = 1'b0;
		endTest("random operations");
	endtask

	initial begin
		arstN = 1'b0;
		opValid = 1'b0;
		op = '0;
		cfgWrite = 1'b0;
		cfgAddr = aluPkg::CTRL;
		cfgWdata = '0;
		repeat (16) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		testAddSub();
		testLogicShift();
		testSaturate();
		testStatus();
		testBackPressure();
		testRandom();
		$display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
		if (testsFailed == 0 && errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// bounds the run if a handshake never completes
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end
endmodule

`default_nettype wire

//--- Makefile
# Verilator build and run of the execution unit testbench

VERILATOR ?= verilator
TOP ?= aluUnitTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

FAIL_MSG := SOME TESTS FAILED
PASS_MSG := ALL TESTS PASSED
SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv) $(wildcard testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src.f
verilog/aluPkg.sv
verilog/claAdder32.sv
verilog/aluLogicShift.sv
verilog/aluRegs.sv
verilog/opQueue.sv
verilog/aluCore.sv
verilog/aluUnit.sv
testbench/aluUnit_props.sv
testbench/aluUnitTb.sv
